/* common/parking_config.svh */
// tower sizes, plate categories and fee rates
// floor 0 is the ground bay and never holds a parked car
`ifndef PARKING_CONFIG_SVH
`define PARKING_CONFIG_SVH

// seven parking floors, two spots each
`define PARK_FLOORS 7
`define PARK_FLOOR_W 3

`define PARK_QUEUE_DEPTH 8

// fees saturate at the top of this width
`define PARK_FEE_W 8

// category nibble of the plate
`define PARK_CAT_DISABLED 4'd9
`define PARK_CAT_HYBRID 4'd8

// fee steps per cycle; disabled plates pay nothing
`define PARK_RATE_STD 2'd2
`define PARK_RATE_HYBRID 2'd1

`endif

/* common/parking_pkg.sv */
// shared types of the parking tower
// a plate of all zeros marks an empty spot, so no real plate may be zero
`default_nettype none

`include "parking_config.svh"

package parking_pkg;

	// low bit is the parity, 1 for SUV
	typedef struct packed {
		logic [3:0]  category;
		logic [10:0] serial;
		logic        suv;
	} plate_t;

	// floor 1 to 7, side 0 left
	typedef struct packed {
		logic [`PARK_FLOOR_W-1:0] floor;
		logic                     side;
	} spot_t;

	typedef struct packed {
		plate_t plate;
		logic   exit;
	} request_t;

	typedef struct packed {
		plate_t                 plate;
		spot_t                  spot;
		logic [`PARK_FEE_W-1:0] fee;
		logic                   ok;
		logic                   exit;
	} result_t;

	// zero plate clears the spot
	typedef struct packed {
		logic   en;
		spot_t  spot;
		plate_t plate;
	} table_write_t;

	// entry index is (floor - 1) * 2 + side
	typedef plate_t [2*`PARK_FLOORS-1:0] lot_state_t;

endpackage

`default_nettype wire

/* logic/order_queue.sv */
// circular FIFO of park and exit orders, kept in arrival order
// push and pop may happen in the same cycle; depth must be at least 2
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module order_queue (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   req_valid,
	input  wire parking_pkg::request_t  req,
	output logic                        req_ready,
	input  wire logic                   pop,
	output logic                        head_valid,
	output parking_pkg::request_t       head
);

	localparam int DEPTH = `PARK_QUEUE_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	parking_pkg::request_t mem [DEPTH];
	logic [PTR_W-1:0]      wr_ptr;
	logic [PTR_W-1:0]      rd_ptr;
	logic [CNT_W-1:0]      count;
	logic                  push;
	logic                  take;

	assign req_ready  = count != CNT_W'(DEPTH);
	assign head_valid = count != '0;
	assign head       = mem[rd_ptr];

	assign push = req_valid && req_ready;
	// a pop on an empty queue is ignored
	assign take = pop && head_valid;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= req;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (take) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// count only moves when one side acts alone
			if (push && !take) begin
				count <= count + 1'b1;
			end else if (take && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* logic/spot_allocator.sv */
// spot choice for the order at the queue head, closest floor first
// sedans overflow to odd floors only when no even spot is usable for them
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module spot_allocator (
	input  wire parking_pkg::request_t    head,
	input  wire parking_pkg::lot_state_t  lot,
	output parking_pkg::spot_t            target,
	output logic                          found
);

	logic [`PARK_FLOORS:1] left_ok;
	logic [`PARK_FLOORS:1] right_ok;
	logic [`PARK_FLOORS:1] type_ok;
	logic                  is_disabled;
	logic                  even_avail;

	// free spots this car may use, before the car type is applied
	always_comb begin
		is_disabled = head.plate.category == `PARK_CAT_DISABLED;
		even_avail  = 1'b0;
		for (int f = 1; f <= `PARK_FLOORS; f++) begin
			// left spots of floors 1 and 2 are held for disabled plates
			left_ok[f]  = (lot[2*f-2] == '0) && (f > 2 || is_disabled);
			right_ok[f] = lot[2*f-1] == '0;
			if (f % 2 == 0) begin
				even_avail = even_avail | left_ok[f] | right_ok[f];
			end
		end
		for (int f = 1; f <= `PARK_FLOORS; f++) begin
			if (f % 2 == 1) begin
				type_ok[f] = head.plate.suv || !even_avail;
			end else begin
				type_ok[f] = !head.plate.suv;
			end
		end
	end

	always_comb begin
		target = '0;
		found  = 1'b0;
		if (head.exit) begin
			// plate lookup, lowest floor and left side first
			for (int f = 1; f <= `PARK_FLOORS; f++) begin
				for (int s = 0; s < 2; s++) begin
					if (!found && head.plate != '0 && lot[2*f-2+s] == head.plate) begin
						found        = 1'b1;
						target.floor = `PARK_FLOOR_W'(f);
						target.side  = 1'(s);
					end
				end
			end
		end else begin
			for (int f = 1; f <= `PARK_FLOORS; f++) begin
				if (!found && type_ok[f] && (left_ok[f] || right_ok[f])) begin
					found        = 1'b1;
					target.floor = `PARK_FLOOR_W'(f);
					target.side  = !left_ok[f];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* logic/fee_meter.sv */
// fee counter for one spot, saturating at the top of the fee width
// clears one cycle after the spot empties
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module fee_meter (
	input  wire logic               clock,
	input  wire logic               reset,
	input  wire logic               occupied,
	input  wire logic [1:0]         rate,
	output logic [`PARK_FEE_W-1:0]  fee
);

	// one extra bit to catch the overflow
	logic [`PARK_FEE_W:0] sum;

	assign sum = fee + rate;

	always_ff @(posedge clock) begin
		if (reset || !occupied) begin
			fee <= '0;
		end else if (sum[`PARK_FEE_W]) begin
			fee <= '1;
		end else begin
			fee <= sum[`PARK_FEE_W-1:0];
		end
	end

endmodule

`default_nettype wire

/* logic/spot_table.sv */
// plate of every spot plus one fee meter per spot
// spot_fee follows table_wr.spot even when no write is enabled
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module spot_table (
	input  wire logic                       clock,
	input  wire logic                       reset,
	input  wire parking_pkg::table_write_t  table_wr,
	output parking_pkg::lot_state_t         lot,
	output logic [`PARK_FEE_W-1:0]          spot_fee
);

	localparam int SPOTS = 2 * `PARK_FLOORS;

	logic [`PARK_FEE_W-1:0] fees [SPOTS];
	logic [3:0]             wr_idx;

	// floor 1 left is entry 0
	assign wr_idx = {table_wr.spot.floor - 3'd1, table_wr.spot.side};

	always_ff @(posedge clock) begin
		if (reset) begin
			lot <= '0;
		end else if (table_wr.en) begin
			lot[wr_idx] <= table_wr.plate;
		end
	end

	for (genvar i = 0; i < SPOTS; i++) begin : g_meter
		logic [1:0] rate;

		always_comb begin
			if (lot[i].category == `PARK_CAT_DISABLED) begin
				rate = 2'd0;
			end else if (lot[i].category == `PARK_CAT_HYBRID) begin
				rate = `PARK_RATE_HYBRID;
			end else begin
				rate = `PARK_RATE_STD;
			end
		end

		fee_meter i_meter (
			.clock    (clock),
			.reset    (reset),
			.occupied (lot[i] != '0),
			.rate     (rate),
			.fee      (fees[i])
		);
	end

	// floor 0 has no meter
	assign spot_fee = (wr_idx < 4'(SPOTS)) ? fees[wr_idx] : '0;

endmodule

`default_nettype wire

/* elevator/elevator_controller.sv */
// single elevator, one floor per cycle, one job at a time
// a new job is not taken in a cycle where done_valid is high
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module elevator_controller (
	input  wire logic                    clock,
	input  wire logic                    reset,
	input  wire logic                    head_valid,
	input  wire parking_pkg::request_t   head,
	input  wire parking_pkg::spot_t      target,
	input  wire logic                    found,
	input  wire logic [`PARK_FEE_W-1:0]  spot_fee,
	output logic                         pop,
	output parking_pkg::table_write_t    table_wr,
	output logic [`PARK_FLOOR_W-1:0]     car_floor,
	output logic                         busy,
	output logic                         done_valid,
	output parking_pkg::result_t         done
);

	typedef enum logic [2:0] {
		IDLE,
		UP,
		STORE,
		FETCH,
		RETURN
	} state_t;

	state_t                state;
	parking_pkg::plate_t   job_plate;
	parking_pkg::spot_t    job_spot;
	logic                  job_exit;

	// keeps two done pulses from touching
	assign pop  = (state == IDLE) && head_valid && !done_valid;
	assign busy = state != IDLE;

	// spot stays on the job target so the fee mux is addressed
	always_comb begin
		table_wr.en    = (state == STORE) || (state == FETCH);
		table_wr.spot  = job_spot;
		table_wr.plate = (state == STORE) ? job_plate : '0;
	end

	always_ff @(posedge clock) begin
		if (pop) begin
			job_plate <= head.plate;
			job_spot  <= target;
			job_exit  <= head.exit;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state      <= IDLE;
			car_floor  <= '0;
			done_valid <= 1'b0;
		end else begin
			done_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (pop && found) begin
						state <= UP;
					end else if (pop) begin
						// nothing to move, report the refusal at once
						done_valid <= 1'b1;
						done       <= '{plate: head.plate, spot: '0, fee: '0,
							ok: 1'b0, exit: head.exit};
					end
				end
				UP: begin
					if (car_floor != job_spot.floor) begin
						car_floor <= car_floor + 1'b1;
					end
					// fetch lands on arrival, store one cycle later
					if (job_exit && car_floor + 1'b1 == job_spot.floor) begin
						state <= FETCH;
					end else if (!job_exit && car_floor == job_spot.floor) begin
						state      <= STORE;
						done_valid <= 1'b1;
						done       <= '{plate: job_plate, spot: job_spot, fee: '0,
							ok: 1'b1, exit: 1'b0};
					end
				end
				STORE: begin
					state <= RETURN;
				end
				FETCH: begin
					state <= RETURN;
					done  <= '{plate: job_plate, spot: job_spot, fee: spot_fee,
						ok: 1'b1, exit: 1'b1};
				end
				RETURN: begin
					car_floor <= car_floor - 1'b1;
					if (car_floor == `PARK_FLOOR_W'(1)) begin
						state <= IDLE;
						// exit is reported once the car is down at the bay
						done_valid <= job_exit;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/parking_lot.sv */
// parking tower top; one request in flight in the elevator at a time
// done_valid is a single-cycle pulse with no back-pressure
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module parking_lot (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire logic                     req_valid,
	input  wire parking_pkg::request_t    req,
	output logic                          req_ready,
	output logic                          done_valid,
	output parking_pkg::result_t          done,
	output logic [`PARK_FLOOR_W-1:0]      car_floor,
	output logic                          busy
);

	logic                       head_valid;
	parking_pkg::request_t      head;
	logic                       pop;
	parking_pkg::spot_t         target;
	logic                       found;
	parking_pkg::lot_state_t    lot;
	parking_pkg::table_write_t  table_wr;
	logic [`PARK_FEE_W-1:0]     spot_fee;

	order_queue i_queue (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.pop        (pop),
		.head_valid (head_valid),
		.head       (head)
	);

	spot_allocator i_alloc (
		.head   (head),
		.lot    (lot),
		.target (target),
		.found  (found)
	);

	elevator_controller i_elevator (
		.clock      (clock),
		.reset      (reset),
		.head_valid (head_valid),
		.head       (head),
		.target     (target),
		.found      (found),
		.spot_fee   (spot_fee),
		.pop        (pop),
		.table_wr   (table_wr),
		.car_floor  (car_floor),
		.busy       (busy),
		.done_valid (done_valid),
		.done       (done)
	);

	spot_table i_table (
		.clock    (clock),
		.reset    (reset),
		.table_wr (table_wr),
		.lot      (lot),
		.spot_fee (spot_fee)
	);

endmodule

`default_nettype wire

/* verification/parking_lot_props.sv */
// port level checks on the parking tower, bound into parking_lot
// queue fill level is rebuilt here from accepted requests and pops
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module parking_lot_props (
	input wire logic                     clock,
	input wire logic                     reset,
	input wire logic                     req_valid,
	input wire logic                     req_ready,
	input wire logic                     pop,
	input wire logic                     head_valid,
	input wire logic                     done_valid,
	input wire logic [`PARK_FLOOR_W-1:0] car_floor,
	input wire logic                     busy
);

	int fill;
	int assert_failures;

	always_ff @(posedge clock) begin
		if (reset) begin
			fill <= 0;
		end else begin
			fill <= fill + int'(req_valid && req_ready) - int'(pop && head_valid);
		end
	end

	a_done_single: assert property (@(posedge clock) disable iff (reset)
		done_valid |=> !done_valid)
	else begin
		assert_failures++;
		$error("done_valid high for two cycles in a row");
	end

	// one floor per cycle, so a wrap past the top floor or below the bay shows as a jump
	a_floor_step: assert property (@(posedge clock) disable iff (reset)
		(int'(car_floor) - int'($past(car_floor))) inside {-1, 0, 1})
	else begin
		assert_failures++;
		$error("car_floor jumped, it wrapped past the top floor or the bay");
	end

	a_full_not_ready: assert property (@(posedge clock) disable iff (reset)
		(fill == `PARK_QUEUE_DEPTH) |-> !req_ready)
	else begin
		assert_failures++;
		$error("req_ready high with a full queue");
	end

	// elevator idle right after reset
	a_idle_after_reset: assert property (@(posedge clock) reset |=> !busy)
	else begin
		assert_failures++;
		$error("busy high in the cycle after reset");
	end

endmodule

`default_nettype wire

/* verification/parking_lot_tb.sv */
// directed testbench for the parking tower with its own spot table model
// tests run one after another and each starts from a fresh reset
`timescale 1ns/10ps
`default_nettype none

`include "parking_config.svh"

module parking_lot_tb;

	localparam int SPOTS   = 2 * `PARK_FLOORS;
	localparam int TIMEOUT = 200;
	localparam int FEE_MAX = (1 << `PARK_FEE_W) - 1;

	logic                      clock;
	logic                      reset;
	logic                      req_valid;
	parking_pkg::request_t     req;
	logic                      req_ready;
	logic                      done_valid;
	parking_pkg::result_t      done;
	logic [`PARK_FLOOR_W-1:0]  car_floor;
	logic                      busy;

	parking_pkg::plate_t  model_lot [SPOTS];
	parking_pkg::result_t done_log [$];
	logic [`PARK_FLOOR_W-1:0] floor_log [$];
	logic                     busy_log [$];
	logic [`PARK_FLOOR_W-1:0] done_floor;
	logic                     done_busy;
	int                   cycle;
	int                   seed;
	bit                   hung;
	int                   spot_errors;
	int                   plate_errors;
	int                   fee_errors;
	int                   flag_errors;
	int                   floor_errors;
	int                   other_errors;
	int                   total_errors;

	parking_lot i_dut (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.done_valid (done_valid),
		.done       (done),
		.car_floor  (car_floor),
		.busy       (busy)
	);

	bind parking_lot parking_lot_props i_props (
		.clock      (clock),
		.reset      (reset),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.pop        (pop),
		.head_valid (head_valid),
		.done_valid (done_valid),
		.car_floor  (car_floor),
		.busy       (busy)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// done pulses are logged at the edge that ends them
	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (done_valid) begin
			done_log.push_back(done);
			floor_log.push_back(car_floor);
			busy_log.push_back(busy);
		end
	end

	task automatic compare_spot(input parking_pkg::spot_t exp, input parking_pkg::spot_t got,
		input string what);
		if (got !== exp) begin
			spot_errors++;
			$display("ERROR %0t: %s got floor %0d side %0d, expected floor %0d side %0d",
				$time, what, got.floor, got.side, exp.floor, exp.side);
		end
	endtask

	task automatic compare_plate(input parking_pkg::plate_t exp, input parking_pkg::plate_t got,
		input string what);
		if (got !== exp) begin
			plate_errors++;
			$display("ERROR %0t: %s got plate %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic compare_fee(input int lo, input int hi, input logic [`PARK_FEE_W-1:0] got,
		input string what);
		if ($isunknown(got) || got < lo || got > hi) begin
			fee_errors++;
			$display("ERROR %0t: %s got fee %0d, expected %0d to %0d", $time, what, got, lo, hi);
		end
	endtask

	task automatic compare_flag(input logic exp, input logic got, input string what);
		if (got !== exp) begin
			flag_errors++;
			$display("ERROR %0t: %s got %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_floor(input logic [`PARK_FLOOR_W-1:0] exp,
		input logic [`PARK_FLOOR_W-1:0] got, input string what);
		if (got !== exp) begin
			floor_errors++;
			$display("ERROR %0t: %s got floor %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic note_hang(input string what);
		if (!hung) begin
			other_errors++;
			hung = 1'b1;
			$display("timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT);
		end
	endtask

	function automatic parking_pkg::spot_t spot_at(int floor, logic side);
		parking_pkg::spot_t s;
		s.floor = `PARK_FLOOR_W'(floor);
		s.side  = side;
		return s;
	endfunction

	function automatic parking_pkg::plate_t new_plate(logic [3:0] category, logic suv);
		parking_pkg::plate_t p;
		p.category = category;
		p.serial   = 11'($random(seed));
		p.suv      = suv;
		return p;
	endfunction

	function automatic parking_pkg::request_t to_req(parking_pkg::plate_t p, logic leave);
		parking_pkg::request_t r;
		r.plate = p;
		r.exit  = leave;
		return r;
	endfunction

	// model index is (floor - 1) * 2 + side
	function automatic bit may_use(int idx, parking_pkg::plate_t p);
		bit held;
		held = (idx < 4) && (idx % 2 == 0) && (p.category != `PARK_CAT_DISABLED);
		return (model_lot[idx] == '0) && !held;
	endfunction

	function automatic int park_choice(parking_pkg::plate_t p);
		bit even_left;
		bit floor_ok;
		even_left = 1'b0;
		for (int i = 0; i < SPOTS; i++) begin
			if ((i / 2) % 2 == 1 && may_use(i, p)) begin
				even_left = 1'b1;
			end
		end
		for (int f = 1; f <= `PARK_FLOORS; f++) begin
			// SUVs odd only, sedans spill upward once the even floors are gone
			floor_ok = p.suv ? (f % 2 == 1) : ((f % 2 == 0) || !even_left);
			if (floor_ok && may_use(2 * f - 2, p)) begin
				return 2 * f - 2;
			end
			if (floor_ok && may_use(2 * f - 1, p)) begin
				return 2 * f - 1;
			end
		end
		return -1;
	endfunction

	function automatic int exit_choice(parking_pkg::plate_t p);
		for (int i = 0; i < SPOTS; i++) begin
			if (model_lot[i] == p) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic predict(input parking_pkg::request_t r, output parking_pkg::result_t e);
		int idx;
		idx = r.exit ? exit_choice(r.plate) : park_choice(r.plate);
		e = '0;
		e.plate = r.plate;
		e.exit  = r.exit;
		e.ok    = idx >= 0;
		if (idx >= 0) begin
			e.spot = spot_at(idx / 2 + 1, idx % 2 != 0);
			model_lot[idx] = r.exit ? '0 : r.plate;
		end
	endtask

	// entered just after a falling edge, leaves req_valid high
	task automatic push_request(input parking_pkg::request_t r);
		int waited;
		waited = 0;
		if (!hung) begin
			req_valid = 1'b1;
			req       = r;
			while (!req_ready && waited < TIMEOUT) begin
				@(negedge clock);
				waited++;
			end
			if (!req_ready) begin
				note_hang("req_ready never came back");
			end
			@(negedge clock);
		end
	endtask

	task automatic wait_done(output parking_pkg::result_t got);
		int waited;
		waited = 0;
		got = '0;
		done_floor = '0;
		done_busy  = 1'b0;
		while (done_log.size() == 0 && waited < TIMEOUT && !hung) begin
			@(negedge clock);
			waited++;
		end
		if (done_log.size() == 0) begin
			note_hang("no done pulse arrived");
		end else begin
			got = done_log.pop_front();
			done_floor = floor_log.pop_front();
			done_busy  = busy_log.pop_front();
		end
	endtask

	task automatic check_result(input parking_pkg::result_t e, input parking_pkg::result_t got,
		input string what);
		compare_plate(e.plate, got.plate, what);
		compare_flag(e.exit, got.exit, {what, " exit flag"});
		compare_flag(e.ok, got.ok, {what, " ok flag"});
		if (e.ok) begin
			compare_spot(e.spot, got.spot, what);
		end
		// a park is reported in the store cycle up at its floor, all else back at the bay
		compare_floor((e.ok && !e.exit) ? e.spot.floor : '0, done_floor, {what, " car floor"});
		compare_flag(e.ok && !e.exit, done_busy, {what, " busy"});
	endtask

	task automatic run_request(input parking_pkg::request_t r, input string what,
		output parking_pkg::result_t got);
		parking_pkg::result_t e;
		predict(r, e);
		@(negedge clock);
		push_request(r);
		req_valid = 1'b0;
		wait_done(got);
		check_result(e, got, what);
	endtask

	task automatic reset_dut();
		@(negedge clock);
		reset     = 1'b1;
		req_valid = 1'b0;
		repeat (5) @(negedge clock);
		reset = 1'b0;
		done_log.delete();
		floor_log.delete();
		busy_log.delete();
		for (int i = 0; i < SPOTS; i++) begin
			model_lot[i] = '0;
		end
	endtask

	task automatic test_type_floors();
		parking_pkg::result_t got;
		reset_dut();
		for (int i = 0; i < 3; i++) begin
			run_request(to_req(new_plate(4'd3, 1'b1), 1'b0), "suv park", got);
			run_request(to_req(new_plate(4'd3, 1'b0), 1'b0), "sedan park", got);
		end
	endtask

	task automatic test_disabled_left();
		parking_pkg::result_t got;
		reset_dut();
		run_request(to_req(new_plate(4'd2, 1'b0), 1'b0), "plain sedan", got);
		compare_spot(spot_at(2, 1'b1), got.spot, "plain sedan on floor 2");
		run_request(to_req(new_plate(`PARK_CAT_DISABLED, 1'b0), 1'b0), "disabled sedan", got);
		compare_spot(spot_at(2, 1'b0), got.spot, "disabled sedan on floor 2");
	endtask

	task automatic test_overflow();
		parking_pkg::result_t got;
		reset_dut();
		// the disabled car takes the held left spot of floor 2
		run_request(to_req(new_plate(`PARK_CAT_DISABLED, 1'b0), 1'b0), "even fill", got);
		for (int i = 0; i < 5; i++) begin
			run_request(to_req(new_plate(4'd3, 1'b0), 1'b0), "even fill", got);
		end
		run_request(to_req(new_plate(4'd3, 1'b0), 1'b0), "overflow sedan", got);
		compare_spot(spot_at(1, 1'b1), got.spot, "first overflow sedan");
		for (int i = 0; i < 6; i++) begin
			run_request(to_req(new_plate(4'd3, 1'b0), 1'b0), "odd fill", got);
		end
		run_request(to_req(new_plate(4'd3, 1'b0), 1'b0), "sedan with no room", got);
		compare_flag(1'b0, got.ok, "full tower sedan ok");
		run_request(to_req(new_plate(4'd3, 1'b1), 1'b0), "suv with no room", got);
		compare_flag(1'b0, got.ok, "full tower suv ok");
	endtask

	task automatic test_exit();
		parking_pkg::result_t got;
		parking_pkg::plate_t  car;
		parking_pkg::plate_t  ghost;
		parking_pkg::spot_t   first_spot;
		reset_dut();
		car = new_plate(4'd3, 1'b1);
		run_request(to_req(car, 1'b0), "park before exit", got);
		// an SUV in an empty tower lands on floor 1 right
		first_spot = spot_at(1, 1'b1);
		run_request(to_req(new_plate(`PARK_CAT_HYBRID, 1'b0), 1'b0), "second car", got);
		run_request(to_req(car, 1'b1), "exit", got);
		compare_spot(first_spot, got.spot, "exit spot");
		run_request(to_req(new_plate(4'd3, 1'b1), 1'b0), "reuse park", got);
		compare_spot(first_spot, got.spot, "reused spot");
		ghost.category = 4'hf;
		ghost.serial   = 11'h7ff;
		ghost.suv      = 1'b1;
		run_request(to_req(ghost, 1'b1), "unknown plate exit", got);
	endtask

	// parks, idles for hold cycles, then leaves
	task automatic timed_stay(input parking_pkg::plate_t p, input int hold, output int stay,
		output logic [`PARK_FEE_W-1:0] fee);
		parking_pkg::result_t got;
		int parked_at;
		run_request(to_req(p, 1'b0), "timed park", got);
		parked_at = cycle;
		repeat (hold) @(negedge clock);
		stay = cycle - parked_at;
		run_request(to_req(p, 1'b1), "timed exit", got);
		fee = got.fee;
	endtask

	task automatic test_fees();
		int                     stay;
		int                     lo;
		int                     hi;
		logic [`PARK_FEE_W-1:0] fee;
		reset_dut();
		timed_stay(new_plate(`PARK_CAT_DISABLED, 1'b0), 10 + ($random(seed) & 15), stay, fee);
		compare_fee(0, 0, fee, "disabled fee");
		timed_stay(new_plate(`PARK_CAT_HYBRID, 1'b1), 20 + ($random(seed) & 31), stay, fee);
		compare_fee(stay, stay + 20, fee, "hybrid fee");
		for (int i = 0; i < 2; i++) begin
			// second round stays long enough to saturate
			timed_stay(new_plate(4'd5, 1'b0), 20 + 120 * i + ($random(seed) & 31), stay, fee);
			lo = (2 * stay > FEE_MAX) ? FEE_MAX : 2 * stay;
			hi = (2 * stay + 40 > FEE_MAX) ? FEE_MAX : 2 * stay + 40;
			compare_fee(lo, hi, fee, "standard fee");
			compare_flag(1'b0, fee[0] && fee != FEE_MAX, "standard fee odd");
		end
	endtask

	task automatic test_backpressure();
		parking_pkg::plate_t   cars [7];
		parking_pkg::request_t burst [9];
		parking_pkg::result_t  exp [9];
		parking_pkg::result_t  got;
		int                    waited;
		reset_dut();
		for (int i = 0; i < 7; i++) begin
			cars[i] = new_plate(4'd3, 1'b1);
			run_request(to_req(cars[i], 1'b0), "setup park", got);
		end
		// top floor car leaves first so the elevator stays busy
		for (int i = 0; i < 7; i++) begin
			burst[i] = to_req(cars[6 - i], 1'b1);
		end
		burst[7] = to_req(new_plate(4'd2, 1'b1), 1'b0);
		burst[8] = to_req(new_plate(4'd2, 1'b1), 1'b0);
		for (int i = 0; i < 9; i++) begin
			predict(burst[i], exp[i]);
		end
		@(negedge clock);
		for (int i = 0; i < 9; i++) begin
			push_request(burst[i]);
		end
		req_valid = 1'b0;
		waited = 0;
		while (req_ready && waited < 20) begin
			@(negedge clock);
			waited++;
		end
		compare_flag(1'b0, req_ready, "req_ready with a full queue");
		for (int i = 0; i < 9; i++) begin
			wait_done(got);
			check_result(exp[i], got, "burst request");
		end
		repeat (40) @(negedge clock);
		if (done_log.size() != 0) begin
			other_errors++;
			$display("an extra done pulse arrived after the burst at %0t", $time);
		end
	endtask

	initial begin
		seed         = 22;
		hung         = 1'b0;
		reset        = 1'b1;
		req_valid    = 1'b0;
		req          = '0;
		spot_errors  = 0;
		plate_errors = 0;
		fee_errors   = 0;
		flag_errors  = 0;
		floor_errors = 0;
		other_errors = 0;
		test_type_floors();
		test_disabled_left();
		test_overflow();
		test_exit();
		test_fees();
		test_backpressure();
		total_errors = spot_errors + plate_errors + fee_errors + flag_errors + floor_errors
			+ other_errors + i_dut.i_props.assert_failures;
		$display("errors: spot %0d plate %0d fee %0d flag %0d floor %0d other %0d assertion %0d",
			spot_errors, plate_errors, fee_errors, flag_errors, floor_errors, other_errors,
			i_dut.i_props.assert_failures);
		if (total_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* parking_lot.f */
+incdir+common
common/parking_pkg.sv
logic/order_queue.sv
logic/spot_allocator.sv
logic/fee_meter.sv
logic/spot_table.sv
elevator/elevator_controller.sv
logic/parking_lot.sv
verification/parking_lot_props.sv
verification/parking_lot_tb.sv

/* Bender.yml */
package:
  name: parking_lot

sources:
  - include_dirs:
      - common
    files:
      - common/parking_pkg.sv
      - logic/order_queue.sv
      - logic/spot_allocator.sv
      - logic/fee_meter.sv
      - logic/spot_table.sv
      - elevator/elevator_controller.sv
      - logic/parking_lot.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/parking_lot_props.sv
      - verification/parking_lot_tb.sv
